//--- bench/tb_trace_matcher.sv
// trace matcher testbench with a rule and word table, a cycle model of the pipeline and output checks
`timescale 1ns/1ps
`default_nettype none

module tb_trace_matcher import trace_pkg::*; ();
   localparam int BB = 32;
   localparam int NR = 4;
   localparam int TW = 16;
   localparam int DW = 12;
   localparam int PW = 8;
   localparam int ROWS = 8;
   localparam int MAX_DELAY = 7;
   localparam int MAX_WIDTH = 5;
   localparam int LIMIT = 24 + ROWS * 2 * (BB + MAX_DELAY + MAX_WIDTH + 40);
   localparam int unsigned SEED = 32'h7108;

   typedef struct packed {
      lane_mode_t        mode;
      logic [1:0]        idx;
      logic [BB-1:0]     pat;
      logic [BB-1:0]     mask;
      logic [BB-1:0]     word;
      logic [DW-1:0]     delay;
      logic [PW-1:0]     width;
      logic [3:0]        lead;    // filler cycles before the word
      logic [3:0]        flags;   // {rev, on, trig, expect hit}
   } row_t;

   // mode, rule, pattern, mask, word, delay, width, lead filler, {rev, on, trig, expect hit}
   row_t rows [ROWS] = '{
      '{LANES_4, 2'd0, 32'hC0FFEE42, 32'hFFFFFFFF, 32'hC0FFEE42, 12'd0, 8'd0, 4'd3, 4'b0101},
      '{LANES_2, 2'd1, 32'h5A5A1234, 32'hFFFFFFFF, 32'h5A5A1234, 12'd3, 8'd4, 4'd5, 4'b1111},
      '{LANES_1, 2'd2, 32'h8BADF00D, 32'hFFFF0000, 32'h8BAD1234, 12'd0, 8'd2, 4'd2, 4'b0111},
      '{LANES_1, 2'd2, 32'h8BADF00D, 32'hFFFF0000, 32'h8AAD0000, 12'd5, 8'd1, 4'd1, 4'b1110},
      '{LANES_4, 2'd3, 32'h0000ABCD, 32'h0000FFFF, 32'hABCDABCD, 12'd0, 8'd0, 4'd0, 4'b0101},
      '{LANES_2, 2'd3, 32'hC0FFEE42, 32'hFFFF00FF, 32'hC0FFEE42, 12'd2, 8'd0, 4'd2, 4'b0111},
      '{LANES_4, 2'd1, 32'h5A5A1234, 32'hFFFFFFFF, 32'h5A5A1234, 12'd1, 8'd3, 4'd4, 4'b1010},
      '{LANES_4, 2'd2, 32'h12345678, 32'hFFFFFFFF, 32'h12345678, 12'd7, 8'd5, 4'd3, 4'b1111}
   };

   logic trace_clk, reset, arm, reverse_data, rule_wr, rule_on, rule_trig;
   logic [TRACE_PINS-1:0] trace_data;
   lane_mode_t            lane_mode;
   logic [1:0]            rule_index, count_sel;
   logic [BB-1:0]         rule_pattern, rule_mask, match_window;
   logic [DW-1:0]         trigger_delay;
   logic [PW-1:0]         trigger_width;
   logic                  match_valid, trig_out, armed;
   logic [NR-1:0]         match_rules;
   logic [TW-1:0]         match_time;
   hit_count_t            hit_count;

   // model state
   logic [BB-1:0] m_pat [NR];
   logic [BB-1:0] m_mask [NR];
   logic [NR-1:0] m_on, m_trig, m_ev_rules;
   logic [BB-1:0] m_window, m_ev_window;
   logic [TW-1:0] m_since, m_wtime, m_ev_time;
   logic          m_ev_valid, m_armed, m_started;
   int            m_fill, m_count [NR], t_start, t_end, edge_n;
   int            mismatches = 0;
   int            failures = 0;
   int            cyc_count = 0;

   trace_matcher_top #(
      .BUFFER_BITS(BB), .MATCH_RULES(NR), .TIMESTAMP_WIDTH(TW),
      .DELAY_WIDTH(DW), .PULSE_WIDTH_BITS(PW)
   ) UUT (
      .trace_clk(trace_clk), .reset(reset), .arm(arm), .trace_data(trace_data),
      .lane_mode(lane_mode), .reverse_data(reverse_data), .rule_wr(rule_wr),
      .rule_index(rule_index), .rule_pattern(rule_pattern), .rule_mask(rule_mask),
      .rule_on(rule_on), .rule_trig(rule_trig), .trigger_delay(trigger_delay),
      .trigger_width(trigger_width), .count_sel(count_sel), .match_valid(match_valid),
      .match_rules(match_rules), .match_window(match_window), .match_time(match_time),
      .hit_count(hit_count), .trig_out(trig_out), .armed(armed)
   );

   initial begin
      trace_clk = 1'b0;
      forever #5 trace_clk = ~trace_clk;
   end

   always @(posedge trace_clk) begin
      cyc_count = cyc_count + 1;
      if (cyc_count > LIMIT) begin
         $display("timeout: run still going after %0d cycles", cyc_count);
         $display("** FAIL **");
         $finish;
      end
   end

   task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] expected);
      mismatches++;
      $display("MISMATCH %s: got %0h expected %0h at cycle %0d", name, got, expected, edge_n);
   endtask

   task automatic report_failure(string what);
      failures++;
      $display("error at cycle %0d: %s", edge_n, what);
   endtask

   function automatic logic [NR-1:0] rule_hits(logic [BB-1:0] w);
      logic [NR-1:0] h;
      for (int i = 0; i < NR; i++) begin
         h[i] = m_on[i] && ((w & m_mask[i]) == (m_pat[i] & m_mask[i]));   // equal under mask
      end
      return h;
   endfunction

   // model of one rising edge with the inputs now driven
   task automatic model_edge();
      logic [NR-1:0] hit;
      logic          wvalid;
      int            k;
      hit    = rule_hits(m_window);
      wvalid = (m_fill >= BB);
      k = (lane_mode == LANES_1) ? 1 : (lane_mode == LANES_2) ? 2 : 4;
      edge_n++;
      if (reset) begin
         m_armed   = 1'b0;
         m_started = 1'b0;
      end else if (arm) begin
         m_armed   = 1'b1;
         m_started = 1'b0;
      end else if (m_armed && !m_started && m_ev_valid && |(m_ev_rules & m_trig)) begin
         m_started = 1'b1;
         t_start   = edge_n + int'(trigger_delay);
         t_end     = (trigger_width == '0) ? edge_n : t_start + int'(trigger_width);
      end
      m_ev_valid  = !reset && wvalid && (|hit) && !arm;
      m_ev_rules  = hit;
      m_ev_window = m_window;
      m_ev_time   = m_wtime;
      for (int i = 0; i < NR; i++) begin
         if (reset || arm)
            m_count[i] = 0;
         else if (wvalid && hit[i] && m_count[i] < (1 << HIT_COUNT_WIDTH) - 1)
            m_count[i]++;
      end
      for (int b = k - 1; b >= 0; b--) begin   // oldest bit first
         m_window = {m_window[BB-2:0], reverse_data ? trace_data[k-1-b] : trace_data[b]};
      end
      m_wtime = m_since;
      if (reset || arm) begin
         m_fill  = 0;
         m_since = '0;
      end else begin
         if (m_fill < BB)
            m_fill += k;
         m_since = m_since + 1'b1;
      end
      if (rule_wr) begin
         m_pat[rule_index]  = rule_pattern;
         m_mask[rule_index] = rule_mask;
         m_on[rule_index]   = rule_on;
         m_trig[rule_index] = rule_trig;
      end
      if (reset) begin
         m_on   = '0;
         m_trig = '0;
      end
   endtask

   task automatic check_outputs();
      logic exp_trig;
      logic exp_armed;
      exp_trig  = m_started && edge_n >= t_start && edge_n < t_end;
      exp_armed = m_armed && !(m_started && edge_n >= t_end);
      if (m_ev_valid && !match_valid)
         report_failure("expected match event did not appear");
      else if (match_valid !== m_ev_valid)
         report_mismatch("match_valid", 64'(match_valid), 64'(m_ev_valid));
      if (m_ev_valid && match_valid) begin
         if (match_rules !== m_ev_rules)
            report_mismatch("match_rules", 64'(match_rules), 64'(m_ev_rules));
         if (match_window !== m_ev_window)
            report_mismatch("match_window", 64'(match_window), 64'(m_ev_window));
         if (match_time !== m_ev_time)
            report_mismatch("match_time", 64'(match_time), 64'(m_ev_time));
      end
      if (hit_count !== hit_count_t'(m_count[count_sel]))
         report_mismatch("hit_count", 64'(hit_count), 64'(m_count[count_sel]));
      if (exp_trig && !trig_out)
         report_failure("trigger pulse missing");
      else if (trig_out !== exp_trig)
         report_mismatch("trig_out", 64'(trig_out), 64'(exp_trig));
      if (armed !== exp_armed)
         report_mismatch("armed", 64'(armed), 64'(exp_armed));
   endtask

   // model the edge and check at the next falling edge
   task automatic tick();
      model_edge();
      @(negedge trace_clk);
      check_outputs();
   endtask

   task automatic filler();
      trace_data = TRACE_PINS'($urandom);
      tick();
   endtask

   task automatic run_row(row_t r);
      int                    k;
      logic [TRACE_PINS-1:0] chunk;
      logic [TRACE_PINS-1:0] d;
      k = (r.mode == LANES_1) ? 1 : (r.mode == LANES_2) ? 2 : 4;
      rule_wr       = 1'b1;
      rule_index    = r.idx;
      rule_pattern  = r.pat;
      rule_mask     = r.mask;
      rule_on       = r.flags[2];
      rule_trig     = r.flags[1];
      lane_mode     = r.mode;
      reverse_data  = r.flags[3];
      trigger_delay = r.delay;
      trigger_width = r.width;
      count_sel     = r.idx;
      tick();
      rule_wr = 1'b0;
      arm     = 1'b1;
      tick();
      arm = 1'b0;
      repeat (2) begin   // second pass must not retrigger
         repeat (r.lead) filler();
         for (int j = 0; j < BB / k; j++) begin
            chunk = TRACE_PINS'(r.word >> (BB - (j + 1) * k));
            d = TRACE_PINS'($urandom);   // unused pins carry noise
            for (int b = 0; b < k; b++) begin
               d[b] = r.flags[3] ? chunk[k-1-b] : chunk[b];
            end
            trace_data = d;
            tick();
         end
         filler();
         if (r.flags[0] && !match_valid)
            report_failure("no match event two cycles after the word");
         else if (match_valid !== r.flags[0])
            report_mismatch("match_valid at word end", 64'(match_valid), 64'(r.flags[0]));
         repeat (8 + int'(r.delay) + int'(r.width)) filler();
      end
   endtask

   initial begin
      void'($urandom(SEED));
      reset = 1'b1;
      arm = 1'b0;
      trace_data = '0;
      lane_mode = LANES_4;
      reverse_data = 1'b0;
      rule_wr = 1'b0;
      rule_index = '0;
      rule_pattern = '0;
      rule_mask = '0;
      rule_on = 1'b0;
      rule_trig = 1'b0;
      trigger_delay = '0;
      trigger_width = '0;
      count_sel = '0;
      m_window = '0;
      m_since = '0;
      m_wtime = '0;
      m_fill = 0;
      m_ev_valid = 1'b0;
      m_armed = 1'b0;
      m_started = 1'b0;
      edge_n = 0;
      repeat (8) tick();
      reset = 1'b0;
      for (int r = 0; r < ROWS; r++) begin
         run_row(rows[r]);
      end
      arm = 1'b1;   // last arm clears the counters
      tick();
      arm = 1'b0;
      repeat (4) filler();
      $display("checks done: %0d mismatches, %0d other errors", mismatches, failures);
      if (mismatches + failures == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

//--- hdl/match_if.sv
// match event bus from the pattern matcher to the trigger and the outputs
`timescale 1ns/1ps
`default_nettype none

interface match_if #(
   parameter int BUFFER_BITS     = 32,
   parameter int MATCH_RULES     = 4,
   parameter int TIMESTAMP_WIDTH = 16
);
   logic                       valid;       // one cycle per event
   logic [MATCH_RULES-1:0]     rules;       // which rules hit
   logic [BUFFER_BITS-1:0]     window;
   logic [TIMESTAMP_WIDTH-1:0] timestamp;

   modport source (output valid, rules, window, timestamp);
   modport sink   (input valid, rules, window, timestamp);
endinterface

`default_nettype wire

//--- hdl/pattern_matcher.sv
// pattern matcher: masked compare against all rules, event register, hit counters
`timescale 1ns/1ps
`default_nettype none

module pattern_matcher import trace_pkg::*; #(
   parameter int BUFFER_BITS     = 32,
   parameter int MATCH_RULES     = 4,
   parameter int TIMESTAMP_WIDTH = 16
) (
   input  logic                           trace_clk,
   input  logic                           reset,
   input  logic                           arm,
   input  logic [BUFFER_BITS-1:0]         window,
   input  logic                           window_valid,
   input  logic [TIMESTAMP_WIDTH-1:0]     window_time,
   rule_bank_if.matcher                   rules,
   match_if.source                        events,
   input  logic [$clog2(MATCH_RULES)-1:0] count_sel,
   output hit_count_t                     hit_count
);
   logic [MATCH_RULES-1:0] hit;
   hit_count_t             counts [MATCH_RULES];

   // all rules in parallel
   always_comb begin
      for (int i = 0; i < MATCH_RULES; i++) begin
         hit[i] = rules.rule_enable[i] &&
                  (((window ^ rules.pattern[i]) & rules.mask[i]) == '0);
      end
   end

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         events.valid <= 1'b0;
         events.rules <= '0;
      end else begin
         // no event from a window seen on the arm cycle
         events.valid <= window_valid && (|hit) && !arm;
         events.rules <= window_valid ? hit : '0;
      end
   end

   always_ff @(posedge trace_clk) begin
      events.window    <= window;
      events.timestamp <= window_time;
   end

   always_ff @(posedge trace_clk) begin
      if (reset || arm) begin
         for (int i = 0; i < MATCH_RULES; i++) begin
            counts[i] <= '0;
         end
      end else if (window_valid) begin
         for (int i = 0; i < MATCH_RULES; i++) begin
            if (hit[i] && (counts[i] != '1))   // saturate at all ones
               counts[i] <= counts[i] + 1'b1;
         end
      end
   end

   assign hit_count = counts[count_sel];

endmodule

`default_nettype wire

//--- hdl/rule_bank.sv
// rule bank: pattern, mask and enable storage, one rule written per strobe
`timescale 1ns/1ps
`default_nettype none

module rule_bank #(
   parameter int BUFFER_BITS = 32,
   parameter int MATCH_RULES = 4
) (
   input  logic                           trace_clk,
   input  logic                           reset,
   input  logic                           rule_wr,
   input  logic [$clog2(MATCH_RULES)-1:0] rule_index,
   input  logic [BUFFER_BITS-1:0]         rule_pattern,
   input  logic [BUFFER_BITS-1:0]         rule_mask,
   input  logic                           rule_on,
   input  logic                           rule_trig,
   rule_bank_if.bank                      rules
);

   // pattern and mask words
   always_ff @(posedge trace_clk) begin
      if (rule_wr) begin
         rules.pattern[rule_index] <= rule_pattern;
         rules.mask[rule_index]    <= rule_mask;
      end
   end

   // enables come up cleared so no rule hits before it is written
   always_ff @(posedge trace_clk) begin
      if (reset) begin
         rules.rule_enable <= '0;
         rules.trig_enable <= '0;
      end else if (rule_wr) begin
         rules.rule_enable[rule_index] <= rule_on;
         rules.trig_enable[rule_index] <= rule_trig;
      end
   end

endmodule

`default_nettype wire

//--- hdl/rule_bank_if.sv
// rule bank bus: per-rule pattern, mask, match enable and trigger enable
`timescale 1ns/1ps
`default_nettype none

interface rule_bank_if #(
   parameter int BUFFER_BITS = 32,
   parameter int MATCH_RULES = 4
);
   logic [BUFFER_BITS-1:0] pattern [MATCH_RULES];
   logic [BUFFER_BITS-1:0] mask    [MATCH_RULES];   // 1 = bit is compared
   logic [MATCH_RULES-1:0] rule_enable;
   logic [MATCH_RULES-1:0] trig_enable;

   modport bank    (output pattern, mask, rule_enable, trig_enable);
   modport matcher (input pattern, mask, rule_enable);
   modport trigger (input trig_enable);
endinterface

`default_nettype wire

//--- hdl/trace_matcher_top.sv
// trace matcher top: sampler, rule bank, matcher and trigger on one trace clock
`timescale 1ns/1ps
`default_nettype none

module trace_matcher_top import trace_pkg::*; #(
   parameter int BUFFER_BITS      = 32,
   parameter int MATCH_RULES      = 4,
   parameter int TIMESTAMP_WIDTH  = 16,
   parameter int DELAY_WIDTH      = 12,
   parameter int PULSE_WIDTH_BITS = 8
) (
   input  logic                           trace_clk,
   input  logic                           reset,
   input  logic                           arm,
   input  logic [TRACE_PINS-1:0]          trace_data,
   input  lane_mode_t                     lane_mode,
   input  logic                           reverse_data,
   input  logic                           rule_wr,
   input  logic [$clog2(MATCH_RULES)-1:0] rule_index,
   input  logic [BUFFER_BITS-1:0]         rule_pattern,
   input  logic [BUFFER_BITS-1:0]         rule_mask,
   input  logic                           rule_on,
   input  logic                           rule_trig,
   input  logic [DELAY_WIDTH-1:0]         trigger_delay,
   input  logic [PULSE_WIDTH_BITS-1:0]    trigger_width,
   input  logic [$clog2(MATCH_RULES)-1:0] count_sel,
   output logic                           match_valid,
   output logic [MATCH_RULES-1:0]         match_rules,
   output logic [BUFFER_BITS-1:0]         match_window,
   output logic [TIMESTAMP_WIDTH-1:0]     match_time,
   output hit_count_t                     hit_count,
   output logic                           trig_out,
   output logic                           armed
);
   logic [BUFFER_BITS-1:0]     window;
   logic                       window_valid;
   logic [TIMESTAMP_WIDTH-1:0] window_time;

   rule_bank_if #(.BUFFER_BITS(BUFFER_BITS), .MATCH_RULES(MATCH_RULES)) rule_bus ();
   match_if #(
      .BUFFER_BITS     (BUFFER_BITS),
      .MATCH_RULES     (MATCH_RULES),
      .TIMESTAMP_WIDTH (TIMESTAMP_WIDTH)
   ) events ();

   trace_sampler #(.BUFFER_BITS(BUFFER_BITS), .TIMESTAMP_WIDTH(TIMESTAMP_WIDTH)) u_sampler (
      .trace_clk (trace_clk), .reset (reset), .arm (arm),
      .trace_data (trace_data), .lane_mode (lane_mode), .reverse_data (reverse_data),
      .window (window), .window_valid (window_valid), .window_time (window_time)
   );

   rule_bank #(.BUFFER_BITS(BUFFER_BITS), .MATCH_RULES(MATCH_RULES)) u_rule_bank (
      .trace_clk (trace_clk), .reset (reset), .rule_wr (rule_wr), .rule_index (rule_index),
      .rule_pattern (rule_pattern), .rule_mask (rule_mask),
      .rule_on (rule_on), .rule_trig (rule_trig), .rules (rule_bus)
   );

   pattern_matcher #(
      .BUFFER_BITS (BUFFER_BITS), .MATCH_RULES (MATCH_RULES),
      .TIMESTAMP_WIDTH (TIMESTAMP_WIDTH)
   ) u_matcher (
      .trace_clk (trace_clk), .reset (reset), .arm (arm),
      .window (window), .window_valid (window_valid), .window_time (window_time),
      .rules (rule_bus), .events (events), .count_sel (count_sel), .hit_count (hit_count)
   );

   trigger_pulser #(.DELAY_WIDTH(DELAY_WIDTH), .PULSE_WIDTH_BITS(PULSE_WIDTH_BITS)) u_trigger (
      .trace_clk (trace_clk), .reset (reset), .arm (arm),
      .rules (rule_bus), .events (events),
      .trigger_delay (trigger_delay), .trigger_width (trigger_width),
      .trig_out (trig_out), .armed (armed)
   );

   // event bus out to plain ports
   assign match_valid  = events.valid;
   assign match_rules  = events.rules;
   assign match_window = events.window;
   assign match_time   = events.timestamp;

endmodule

`default_nettype wire

//--- hdl/trace_pkg.sv
// trace capture shared types: trace port width, lane modes and hit counter type
`default_nettype none

package trace_pkg;

   // physical trace port, one nibble per clock at most
   localparam int TRACE_PINS = 4;

   // bits taken from the port each cycle
   // code 3 is unused and behaves like LANES_4
   typedef enum logic [1:0] {
      LANES_1 = 2'd0,
      LANES_2 = 2'd1,
      LANES_4 = 2'd2
   } lane_mode_t;

   localparam int HIT_COUNT_WIDTH = 8;   // per-rule counter, saturating

   typedef logic [HIT_COUNT_WIDTH-1:0] hit_count_t;

endpackage

`default_nettype wire

//--- hdl/trace_sampler.sv
// trace sampler: lane select, optional bit reversal, sliding window and timestamp
`timescale 1ns/1ps
`default_nettype none

module trace_sampler import trace_pkg::*; #(
   parameter int BUFFER_BITS     = 32,
   parameter int TIMESTAMP_WIDTH = 16
) (
   input  logic                       trace_clk,
   input  logic                       reset,
   input  logic                       arm,
   input  logic [TRACE_PINS-1:0]      trace_data,
   input  lane_mode_t                 lane_mode,
   input  logic                       reverse_data,
   output logic [BUFFER_BITS-1:0]     window,
   output logic                       window_valid,
   output logic [TIMESTAMP_WIDTH-1:0] window_time
);
   localparam int FILL_WIDTH = $clog2(BUFFER_BITS + 1) + 1;   // room for overshoot

   logic [2:0]                 lane_count;
   logic [TRACE_PINS-1:0]      lane_mask;
   logic [TRACE_PINS-1:0]      rev_data;
   logic [TRACE_PINS-1:0]      lane_bits;
   logic [FILL_WIDTH-1:0]      fill;
   logic [TIMESTAMP_WIDTH-1:0] stamp;

   always_comb begin
      case (lane_mode)
         LANES_1: begin
            lane_count = 3'd1;
            lane_mask  = TRACE_PINS'(1);
         end
         LANES_2: begin
            lane_count = 3'd2;
            lane_mask  = TRACE_PINS'(3);
         end
         default: begin   // LANES_4 and the spare code
            lane_count = 3'd4;
            lane_mask  = '1;
         end
      endcase
      for (int i = 0; i < TRACE_PINS; i++) begin
         rev_data[i] = trace_data[TRACE_PINS-1-i];
      end
      // reversed low k bits end up at the top of rev_data
      lane_bits = reverse_data ? (rev_data >> (TRACE_PINS - lane_count)) : trace_data;
      lane_bits = lane_bits & lane_mask;
   end

   always_ff @(posedge trace_clk) begin
      window      <= (window << lane_count) | BUFFER_BITS'(lane_bits);
      window_time <= stamp;   // cycle in which the newest bits were driven
   end

   always_ff @(posedge trace_clk) begin
      if (reset || arm) begin
         fill  <= '0;
         stamp <= '0;
      end else begin
         if (!window_valid)
            fill <= fill + FILL_WIDTH'(lane_count);
         stamp <= stamp + 1'b1;   // wraps
      end
   end

   assign window_valid = (fill >= FILL_WIDTH'(BUFFER_BITS));

endmodule

`default_nettype wire

//--- hdl/trigger_pulser.sv
// trigger pulser: one delayed pulse of programmable width per arm
`timescale 1ns/1ps
`default_nettype none

module trigger_pulser #(
   parameter int DELAY_WIDTH      = 12,
   parameter int PULSE_WIDTH_BITS = 8
) (
   input  logic                        trace_clk,
   input  logic                        reset,
   input  logic                        arm,
   rule_bank_if.trigger                rules,
   match_if.sink                       events,
   input  logic [DELAY_WIDTH-1:0]      trigger_delay,
   input  logic [PULSE_WIDTH_BITS-1:0] trigger_width,
   output logic                        trig_out,
   output logic                        armed
);
   localparam int COUNT_WIDTH = (DELAY_WIDTH > PULSE_WIDTH_BITS) ? DELAY_WIDTH
                                                                 : PULSE_WIDTH_BITS;

   typedef enum logic [1:0] {IDLE, ARMED, DELAY, PULSE} state_t;

   state_t                 state;
   logic [COUNT_WIDTH-1:0] count;
   logic                   trig_match;

   assign trig_match = events.valid && (|(events.rules & rules.trig_enable));

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         state <= IDLE;
         count <= '0;
      end else if (arm) begin
         state <= ARMED;
         count <= '0;
      end else begin
         case (state)
            ARMED: begin
               if (trig_match) begin
                  if (trigger_width == '0) begin
                     state <= IDLE;   // zero width, nothing to fire
                  end else if (trigger_delay == '0) begin
                     state <= PULSE;
                     count <= COUNT_WIDTH'(trigger_width) - 1'b1;
                  end else begin
                     state <= DELAY;
                     count <= COUNT_WIDTH'(trigger_delay) - 1'b1;
                  end
               end
            end
            DELAY: begin
               if (count != '0) begin
                  count <= count - 1'b1;
               end else if (trigger_width == '0) begin
                  state <= IDLE;
               end else begin
                  state <= PULSE;
                  count <= COUNT_WIDTH'(trigger_width) - 1'b1;
               end
            end
            PULSE: begin
               if (count == '0)
                  state <= IDLE;   // done until next arm
               else
                  count <= count - 1'b1;
            end
            default: state <= IDLE;
         endcase
      end
   end

   assign trig_out = (state == PULSE);
   assign armed    = (state != IDLE);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the trace matcher testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f sources.f \
   --top-module tb_trace_matcher -o tb_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qxF '** PASS **' "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- sources.f
hdl/trace_pkg.sv
hdl/rule_bank_if.sv
hdl/match_if.sv
hdl/trace_sampler.sv
hdl/rule_bank.sv
hdl/pattern_matcher.sv
hdl/trigger_pulser.sv
hdl/trace_matcher_top.sv
bench/tb_trace_matcher.sv
